/* floppy_pkg.sv */
package floppy_pkg;

    // drive count and image geometry.
    localparam int num_drives       = 4;
    localparam int sectors_per_side = 9;
    localparam int sector_bytes     = 512;

    // 9 sectors of 512 bytes fit in 8 KiB.
    localparam int track_addr_bits  = 13;

    // requested or latched head position.
    typedef struct packed {
        logic [6:0] track;
        logic [1:0] drive;
        logic       side;
    } drive_pos_t;

    // block read request to the host.
    typedef struct packed {
        logic [31:0] lba;
        logic [5:0]  blk_cnt;
    } sd_req_t;

endpackage

/* track_dpram.sv */
`timescale 1ns/1ns

module track_dpram #(
    parameter int addr_bits = floppy_pkg::track_addr_bits
) (
    input  logic                 clk,

    input  logic [addr_bits-1:0] address_a,
    input  logic [7:0]           data_a,
    input  logic                 wren_a,
    output logic [7:0]           q_a,

    input  logic [addr_bits-1:0] address_b,
    output logic [7:0]           q_b
);

    logic [7:0] mem [2**addr_bits];

    // host side, write-first.
    always_ff @(posedge clk) begin
        if (wren_a) begin
            mem[address_a] <= data_a;
            q_a <= data_a;
        end else begin
            q_a <= mem[address_a];
        end
    end

    // sector side, read only.
    always_ff @(posedge clk) begin
        q_b <= mem[address_b];
    end

endmodule

/* track_loader.sv */
`timescale 1ns/1ns

module track_loader (
    input  logic                              clk,
    input  logic                              reset,

    input  floppy_pkg::drive_pos_t            pos,
    input  logic                              disk_mounted,
    input  logic                              disk_sides,

    input  logic [floppy_pkg::num_drives-1:0] sd_ack,
    output floppy_pkg::sd_req_t               sd_req [floppy_pkg::num_drives],
    output logic [floppy_pkg::num_drives-1:0] sd_rd,
    output logic [floppy_pkg::num_drives-1:0] sd_wr,

    output floppy_pkg::drive_pos_t            cur_pos,
    output logic                              ready
);
    import floppy_pkg::*;

    logic        load;
    logic        load_busy;
    logic        changed;
    logic        start_load;
    logic        ack_cur;
    logic [31:0] track_lba;

    assign changed    = pos != cur_pos;
    assign ack_cur    = sd_ack[cur_pos.drive];
    assign start_load = load && !load_busy && disk_mounted;
    assign ready      = !changed && !load && !load_busy && disk_mounted;

    // no write-back.
    assign sd_wr = '0;

    // first block of the requested track in the image.
    always_comb begin
        if (disk_sides) begin
            track_lba = 32'(pos.track) * 32'(2 * sectors_per_side);
        end else begin
            track_lba = 32'(pos.track) * 32'(sectors_per_side);
        end
        if (pos.side) begin
            track_lba = track_lba + 32'(sectors_per_side);
        end
    end

    // pending load, held until the host acks.
    always_ff @(posedge clk) begin
        if (reset) begin
            load <= 1'b1;
        end else begin
            if (!load_busy && changed) begin
                load <= 1'b1;
            end
            if (load_busy && ack_cur) begin
                load <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_busy <= 1'b0;
            sd_rd     <= '0;
            cur_pos   <= '0;
        end else begin
            if (start_load) begin
                load_busy        <= 1'b1;
                cur_pos          <= pos;
                sd_rd[pos.drive] <= 1'b1;
            end
            if (load_busy && sd_rd[cur_pos.drive] && ack_cur) begin
                sd_rd[cur_pos.drive] <= 1'b0;
            end
            // transfer over once ack drops.
            if (load_busy && !load && !ack_cur) begin
                load_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_load) begin
            sd_req[pos.drive].lba     <= track_lba;
            sd_req[pos.drive].blk_cnt <= 6'(sectors_per_side - 1);
        end
    end

endmodule

/* track_buffer.sv */
`timescale 1ns/1ns

module track_buffer #(
    parameter int addr_bits = floppy_pkg::track_addr_bits
) (
    input  logic                              clk,
    input  logic                              reset,

    input  floppy_pkg::drive_pos_t            pos,
    input  logic                              disk_mounted,
    input  logic                              disk_sides,

    input  logic [floppy_pkg::num_drives-1:0] sd_ack,
    output floppy_pkg::sd_req_t               sd_req [floppy_pkg::num_drives],
    output logic [floppy_pkg::num_drives-1:0] sd_rd,
    output logic [floppy_pkg::num_drives-1:0] sd_wr,

    input  logic [13:0]                       sd_buff_addr,
    input  logic [7:0]                        sd_buff_dout,
    input  logic                              sd_buff_wr,
    output logic [7:0]                        sd_buff_din [floppy_pkg::num_drives],

    input  logic [addr_bits-1:0]              rd_addr,
    output logic [7:0]                        rd_data,
    output logic                              ready
);
    import floppy_pkg::*;

    drive_pos_t cur_pos;
    logic [7:0] host_q;

    track_loader track_loader_inst (
        .clk          (clk),
        .reset        (reset),
        .pos          (pos),
        .disk_mounted (disk_mounted),
        .disk_sides   (disk_sides),
        .sd_ack       (sd_ack),
        .sd_req       (sd_req),
        .sd_rd        (sd_rd),
        .sd_wr        (sd_wr),
        .cur_pos      (cur_pos),
        .ready        (ready)
    );

    track_dpram #(
        .addr_bits (addr_bits)
    ) track_dpram_inst (
        .clk       (clk),
        .address_a (sd_buff_addr[addr_bits-1:0]),
        .data_a    (sd_buff_dout),
        .wren_a    (sd_buff_wr),
        .q_a       (host_q),
        .address_b (rd_addr),
        .q_b       (rd_data)
    );

    // read-back goes to the loading drive only, other lanes hold.
    always_ff @(posedge clk) begin
        sd_buff_din[cur_pos.drive] <= host_q;
    end

endmodule

/* sector_reader.sv */
`timescale 1ns/1ns

module sector_reader #(
    parameter int addr_bits = floppy_pkg::track_addr_bits
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 start,
    input  logic [3:0]           sector_num,

    output logic [addr_bits-1:0] rd_addr,
    input  logic [7:0]           rd_data,

    output logic [7:0]           data,
    output logic                 valid,
    output logic                 done
);
    import floppy_pkg::*;

    logic       active;
    logic [8:0] byte_cnt;
    logic [3:0] sector_reg;

    assign rd_addr = addr_bits'(sector_reg) * addr_bits'(sector_bytes) + addr_bits'(byte_cnt);

    // RAM output is already registered.
    assign data = rd_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            byte_cnt <= '0;
            valid    <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (!active && start) begin
                active   <= 1'b1;
                byte_cnt <= '0;
            end else if (active) begin
                byte_cnt <= byte_cnt + 9'd1;
                if (byte_cnt == 9'(sector_bytes - 1)) begin
                    active <= 1'b0;
                end
            end
            // one cycle of RAM latency.
            valid <= active;
            done  <= valid && !active;
        end
    end

    always_ff @(posedge clk) begin
        if (!active && start) begin
            sector_reg <= sector_num;
        end
    end

endmodule

/* floppy_track_top.sv */
`timescale 1ns/1ns

module floppy_track_top #(
    parameter int addr_bits = floppy_pkg::track_addr_bits
) (
    input  logic                              clk,
    input  logic                              reset,

    input  floppy_pkg::drive_pos_t            pos,
    input  logic                              disk_mounted,
    input  logic                              disk_sides,

    input  logic [floppy_pkg::num_drives-1:0] sd_ack,
    output floppy_pkg::sd_req_t               sd_req [floppy_pkg::num_drives],
    output logic [floppy_pkg::num_drives-1:0] sd_rd,
    output logic [floppy_pkg::num_drives-1:0] sd_wr,

    input  logic [13:0]                       sd_buff_addr,
    input  logic [7:0]                        sd_buff_dout,
    input  logic                              sd_buff_wr,
    output logic [7:0]                        sd_buff_din [floppy_pkg::num_drives],

    output logic                              ready,

    input  logic                              sector_start,
    input  logic [3:0]                        sector_num,
    output logic [7:0]                        sector_data,
    output logic                              sector_valid,
    output logic                              sector_done
);

    logic [addr_bits-1:0] rd_addr;
    logic [7:0]           rd_data;

    track_buffer #(
        .addr_bits (addr_bits)
    ) track_buffer_inst (
        .clk          (clk),
        .reset        (reset),
        .pos          (pos),
        .disk_mounted (disk_mounted),
        .disk_sides   (disk_sides),
        .sd_ack       (sd_ack),
        .sd_req       (sd_req),
        .sd_rd        (sd_rd),
        .sd_wr        (sd_wr),
        .sd_buff_addr (sd_buff_addr),
        .sd_buff_dout (sd_buff_dout),
        .sd_buff_wr   (sd_buff_wr),
        .sd_buff_din  (sd_buff_din),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .ready        (ready)
    );

    sector_reader #(
        .addr_bits (addr_bits)
    ) sector_reader_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (sector_start),
        .sector_num (sector_num),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .data       (sector_data),
        .valid      (sector_valid),
        .done       (sector_done)
    );

endmodule

/* floppy_track_assert.sv */
`timescale 1ns/1ns

module floppy_track_assert (
    input logic       clk,
    input logic       reset,
    input logic [3:0] sd_rd,
    input logic [3:0] sd_ack,
    input logic       load_busy,
    input logic       ready
);

    // a request only exists inside a load.
    rd_needs_busy: assert property (@(posedge clk) disable iff (reset)
        |sd_rd |-> load_busy)
        else $error("sd_rd high without load_busy");

    rd_drops_on_ack: assert property (@(posedge clk) disable iff (reset)
        |(sd_rd & sd_ack) |=> !(|sd_rd))
        else $error("sd_rd still high after ack");

    // the cache is not ready while the host still transfers.
    ready_not_in_transfer: assert property (@(posedge clk) disable iff (reset)
        |sd_ack |-> !ready)
        else $error("ready high while the host acks a transfer");

endmodule

bind track_loader floppy_track_assert floppy_track_assert_inst (
    .clk       (clk),
    .reset     (reset),
    .sd_rd     (sd_rd),
    .sd_ack    (sd_ack),
    .load_busy (load_busy),
    .ready     (ready)
);

/* tb_floppy_track.sv */
`timescale 1ns/1ns

module tb_floppy_track;
    import floppy_pkg::*;

    logic clk;
    logic reset;
    drive_pos_t pos;
    logic disk_mounted;
    logic disk_sides;
    logic [3:0] sd_ack;
    sd_req_t sd_req [num_drives];
    logic [3:0] sd_rd;
    logic [3:0] sd_wr;
    logic [13:0] sd_buff_addr;
    logic [7:0] sd_buff_dout;
    logic sd_buff_wr;
    logic [7:0] sd_buff_din [num_drives];
    logic ready;
    logic sector_start;
    logic [3:0] sector_num;
    logic [7:0] sector_data;
    logic sector_valid;
    logic sector_done;

    int g_mount [32];
    int g_sides [32];
    int g_track [32];
    int g_drive [32];
    int g_side [32];
    int g_lba [32];
    int g_sector [32];
    int num_lines = 0;
    int pulses [num_drives];
    logic [3:0] rd_prev = '0;
    int host_drive = 0;
    logic wr_d1 = 1'b0;
    logic wr_d2 = 1'b0;
    logic [7:0] data_d1;
    logic [7:0] data_d2;
    logic run_closed = 1'b0;

    floppy_track_top #(
        .addr_bits (track_addr_bits)
    ) floppy_track_top_inst (
        .clk (clk), .reset (reset), .pos (pos),
        .disk_mounted (disk_mounted), .disk_sides (disk_sides),
        .sd_ack (sd_ack), .sd_req (sd_req), .sd_rd (sd_rd), .sd_wr (sd_wr),
        .sd_buff_addr (sd_buff_addr), .sd_buff_dout (sd_buff_dout),
        .sd_buff_wr (sd_buff_wr), .sd_buff_din (sd_buff_din), .ready (ready),
        .sector_start (sector_start), .sector_num (sector_num),
        .sector_data (sector_data), .sector_valid (sector_valid),
        .sector_done (sector_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // byte the host stores at a track offset.
    function automatic logic [7:0] pattern(input logic [31:0] lba, input int addr);
        logic [31:0] sum;
        sum = lba * 32'd7 + 32'(addr);
        return sum[7:0] ^ 8'h5a;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        run_closed = 1'b1;
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_req(input string name, input sd_req_t got, input sd_req_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // rising edges of each request lane.
    always @(negedge clk) begin
        for (int i = 0; i < num_drives; i++) begin
            if (sd_rd[i] && !rd_prev[i]) begin
                pulses[i] = pulses[i] + 1;
            end
        end
        rd_prev = sd_rd;
    end

    // no write-back, so write strobes never rise.
    always @(negedge clk) begin
        check_level("sd_wr", |sd_wr, 1'b0);
    end

    // host read-back, two cycles behind the write.
    always @(negedge clk) begin
        if (wr_d2) begin
            check_byte($sformatf("sd_buff_din[%0d]", host_drive),
                       sd_buff_din[host_drive], data_d2);
        end
        wr_d2 = wr_d1;
        data_d2 = data_d1;
        wr_d1 = sd_buff_wr;
        data_d1 = sd_buff_dout;
    end

    // host block device.
    initial begin
        logic [31:0] req_lba;
        forever begin
            @(negedge clk);
            if (!reset && |sd_rd) begin
                for (int i = 0; i < num_drives; i++) begin
                    if (sd_rd[i]) begin
                        host_drive = i;
                    end
                end
                req_lba = sd_req[host_drive].lba;
                repeat (1 + $urandom % 8) @(posedge clk);
                sd_ack[host_drive] <= 1'b1;
                for (int a = 0; a < sectors_per_side * sector_bytes; a++) begin
                    @(posedge clk);
                    sd_buff_addr <= 14'(a);
                    sd_buff_dout <= pattern(req_lba, a);
                    sd_buff_wr <= 1'b1;
                end
                @(posedge clk);
                sd_buff_wr <= 1'b0;
                sd_ack <= '0;
            end
        end
    end

    initial begin
        wait (num_lines > 0);
        repeat ((num_lines + 2) * 20000) @(posedge clk);
        report_failure("timeout waiting for the DUT");
    end

    task automatic apply_line(input int i);
        @(posedge clk);
        disk_mounted <= g_mount[i] != 0;
        disk_sides <= g_sides[i] != 0;
        pos.track <= 7'(g_track[i]);
        pos.drive <= 2'(g_drive[i]);
        pos.side <= 1'(g_side[i]);
    endtask

    task automatic wait_request(input int i);
        sd_req_t exp;
        @(negedge clk);
        while (!sd_rd[g_drive[i]]) @(negedge clk);
        exp.lba = 32'(g_lba[i]);
        exp.blk_cnt = 6'd8;
        check_req($sformatf("sd_req[%0d]", g_drive[i]), sd_req[g_drive[i]], exp);
    endtask

    task automatic compare_pulses(input int expected [num_drives]);
        for (int d = 0; d < num_drives; d++) begin
            if (pulses[d] != expected[d]) begin
                report_failure($sformatf("drive %0d saw %0d read requests, expected %0d",
                                         d, pulses[d], expected[d]));
            end
        end
    endtask

    task automatic read_sector(input int i);
        @(posedge clk);
        sector_start <= 1'b1;
        sector_num <= 4'(g_sector[i]);
        @(posedge clk);
        sector_start <= 1'b0;
        @(negedge clk);
        while (!sector_valid) @(negedge clk);
        for (int k = 0; k < sector_bytes; k++) begin
            check_level("sector_valid", sector_valid, 1'b1);
            check_byte("sector_data", sector_data,
                       pattern(32'(g_lba[i]), g_sector[i] * sector_bytes + k));
            @(negedge clk);
        end
        check_level("sector_valid", sector_valid, 1'b0);
        check_level("sector_done", sector_done, 1'b1);
    endtask

    initial begin
        int fd;
        int expected [num_drives];
        string text;
        logic loaded;
        void'($urandom(32'h9609b576));
        reset = 1'b1;
        pos = '0;
        disk_mounted = 1'b0;
        disk_sides = 1'b0;
        sd_ack = '0;
        sd_buff_addr = '0;
        sd_buff_dout = '0;
        sd_buff_wr = 1'b0;
        sector_start = 1'b0;
        sector_num = '0;
        loaded = 1'b0;
        for (int d = 0; d < num_drives; d++) begin
            pulses[d] = 0;
        end
        fd = $fopen("floppy_track_golden.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open floppy_track_golden.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 1 && text.getc(0) != 8'h23) begin
                void'($sscanf(text, "%d %d %d %d %d %d %d", g_mount[num_lines],
                              g_sides[num_lines], g_track[num_lines], g_drive[num_lines],
                              g_side[num_lines], g_lba[num_lines], g_sector[num_lines]));
                num_lines++;
            end
        end
        $fclose(fd);
        if (num_lines < 2) begin
            report_failure("golden file holds fewer than two steps");
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_level("ready", ready, 1'b0);
        check_level("sector_valid", sector_valid, 1'b0);
        // nothing may load without a disk.
        repeat (50) begin
            @(negedge clk);
            check_level("sd_rd", |sd_rd, 1'b0);
        end

        for (int i = 0; i < num_lines; i++) begin
            expected = pulses;
            if (loaded && g_track[i] == g_track[i-1] && g_drive[i] == g_drive[i-1]
                       && g_side[i] == g_side[i-1]) begin
                apply_line(i);
                repeat (20) @(negedge clk);
                check_level("ready", ready, 1'b1);
            end else begin
                apply_line(i);
                wait_request(i);
                while (!ready) @(negedge clk);
                expected[g_drive[i]]++;
            end
            compare_pulses(expected);
            loaded = 1'b1;
            read_sector(i);
        end

        // second move while the first load is still running.
        expected = pulses;
        apply_line(0);
        wait_request(0);
        apply_line(1);
        while (sd_rd[g_drive[0]]) @(negedge clk);
        wait_request(1);
        while (!ready) @(negedge clk);
        expected[g_drive[0]]++;
        expected[g_drive[1]]++;
        compare_pulses(expected);
        read_sector(1);

        run_closed = 1'b1;
        $display("Test OK");
        $finish;
    end

    final begin
        if (!run_closed) begin
            $display("Test FAILED");
        end
    end

endmodule

/* floppy_track_golden.txt */
# mount sides track drive side lba sector (decimal)
# lba is the expected first block of the track in the image.
1 1 0 0 0 0 0
1 1 5 1 0 90 3
1 1 5 1 1 99 8
1 1 5 1 1 99 2
1 0 12 2 0 108 4
1 0 12 2 1 117 0
1 1 79 3 1 1431 7
1 0 40 0 0 360 5
1 1 33 2 1 603 1
1 0 7 3 0 63 6

/* project.f */
floppy_pkg.sv
track_dpram.sv
track_loader.sv
track_buffer.sv
sector_reader.sv
floppy_track_top.sv
floppy_track_assert.sv
tb_floppy_track.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_floppy_track
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
